/* hdl/host_link_pkg.sv */
`default_nettype none

package host_link_pkg;

  // host stream and frame message widths
  localparam int host_word_w = 32;
  localparam int frame_msg_w = 64;

  // header layout
  localparam int tag_lsb    = 0;
  localparam int tag_w      = 8;
  localparam int opcode_lsb = 8;
  localparam int opcode_w   = 8;

  localparam logic [tag_w-1:0] hdr_tag = 8'h08;  // low byte of every valid header

  localparam logic [opcode_w-1:0] op_nop    = 8'h00;
  localparam logic [opcode_w-1:0] op_config = 8'h01;
  localparam logic [opcode_w-1:0] op_start  = 8'h09;

  // frame message, msb first: index, stride, exposure bits
  localparam int frame_idx_w      = 16;
  localparam int frame_stride_w   = 16;
  localparam int frame_exposure_w = 32;

  typedef struct packed {
    logic [frame_stride_w-1:0] stride;  // upper half
    logic [15:0]               exposure_clocks;
  } param_cfg_t;

  typedef struct packed {
    logic [15:0] unused;  // ignored by START
    logic [15:0] frame_count;
  } param_run_t;

  // second command word, read as cfg for CONFIG and as run for START
  typedef union packed {
    param_cfg_t cfg;
    param_run_t run;
  } param_word_u;

endpackage

`default_nettype wire

/* hdl/stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter int width = 32,
  parameter int depth = 16
) (
  input  wire logic             BUS_CLK,
  input  wire logic             rst_n,
  input  wire logic [width-1:0] din,
  input  wire logic             wren,
  input  wire logic             rden,
  output logic      [width-1:0] dout,
  output logic                  empty,
  output logic                  full,
  output logic                  high
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  logic [width-1:0] mem [depth];  // no reset on storage
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_write;
  logic             do_read;

  assign do_write = wren && !full;
  assign do_read  = rden && !empty;

  assign dout  = mem[rd_ptr];  // first word falls through
  assign empty = (count == '0);
  assign full  = (count == cnt_w'(depth));
  assign high  = (count >= cnt_w'(depth - 2));  // high-water mark

  always_ff @(posedge BUS_CLK) begin
    if (do_write) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge BUS_CLK or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/cmd_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_assembler (
  input  wire logic                                   BUS_CLK,
  input  wire logic                                   rst_n,
  input  wire logic [host_link_pkg::host_word_w-1:0]  fifo_dout,
  input  wire logic                                   fifo_empty,
  output logic                                        fifo_rden,
  output logic                                        cmd_valid,
  output logic      [host_link_pkg::opcode_w-1:0]     cmd_opcode,
  output host_link_pkg::param_word_u                  cmd_param,
  output logic      [host_link_pkg::host_word_w-1:0]  cmd_exposure,
  output logic                                        cmd_bad,
  input  wire logic                                   cmd_take
);

  import host_link_pkg::*;

  logic [1:0]       word_cnt;  // 0 header, 1 param, 2 exposure
  logic [tag_w-1:0] hdr_tag_r;
  logic             known_op;

  assign fifo_rden = !fifo_empty && !cmd_valid;  // stall while holding

  assign known_op = (cmd_opcode == op_nop) || (cmd_opcode == op_config) ||
                    (cmd_opcode == op_start);
  // nop skips the tag check so an all-zero command passes
  assign cmd_bad  = cmd_valid &&
                    (!known_op || ((cmd_opcode != op_nop) && (hdr_tag_r != hdr_tag)));

  always_ff @(posedge BUS_CLK or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt  <= 2'd0;
      cmd_valid <= 1'b0;
    end else begin
      if (cmd_valid && cmd_take) begin
        cmd_valid <= 1'b0;  // sequencer consumed it
      end
      if (fifo_rden) begin
        if (word_cnt == 2'd2) begin
          word_cnt  <= 2'd0;
          cmd_valid <= 1'b1;
        end else begin
          word_cnt <= word_cnt + 2'd1;
        end
      end
    end
  end

  // payload registers
  always_ff @(posedge BUS_CLK) begin
    if (fifo_rden) begin
      case (word_cnt)
        2'd0: begin
          cmd_opcode <= fifo_dout[opcode_lsb +: opcode_w];
          hdr_tag_r  <= fifo_dout[tag_lsb +: tag_w];
        end
        2'd1:    cmd_param    <= fifo_dout;
        default: cmd_exposure <= fifo_dout;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/frame_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer (
  input  wire logic                                   BUS_CLK,
  input  wire logic                                   rst_n,
  input  wire logic                                   cmd_valid,
  input  wire logic [host_link_pkg::opcode_w-1:0]     cmd_opcode,
  input  wire host_link_pkg::param_word_u             cmd_param,
  input  wire logic [host_link_pkg::host_word_w-1:0]  cmd_exposure,
  input  wire logic                                   cmd_bad,
  output logic                                        cmd_take,
  output logic                                        frame_wren,
  output logic      [host_link_pkg::frame_msg_w-1:0]  frame_data,
  input  wire logic                                   frame_high,
  output logic                                        burst_done,
  output logic                                        app_running,
  output logic                                        app_error
);

  import host_link_pkg::*;

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_wait = 2'd1;  // exposure period running
  localparam logic [1:0] st_emit = 2'd2;

  logic [1:0]                  state;
  logic [frame_stride_w-1:0]   stride;
  logic [15:0]                 exp_clocks;
  logic [frame_exposure_w-1:0] exposure_bits;
  logic [15:0]                 frame_total;
  logic [frame_idx_w-1:0]      frame_idx;
  logic [15:0]                 pace;
  logic                        done_seen;  // a burst has finished since reset

  // a valid CONFIG waits until the burst ends, everything else goes at once
  assign cmd_take = cmd_valid &&
                    ((state == st_idle) || cmd_bad || (cmd_opcode != op_config));

  assign frame_wren  = (state == st_emit) && !frame_high;  // back-pressure
  assign frame_data  = {frame_idx, stride, exposure_bits};
  assign app_running = (state != st_idle);
  assign burst_done  = (state == st_idle) && done_seen;

  always_ff @(posedge BUS_CLK or negedge rst_n) begin
    if (!rst_n) begin
      state         <= st_idle;
      stride        <= '0;
      exp_clocks    <= '0;
      exposure_bits <= '0;
      frame_total   <= '0;
      frame_idx     <= '0;
      pace          <= '0;
      done_seen     <= 1'b0;
      app_error     <= 1'b0;
    end else begin
      if (cmd_take) begin
        if (cmd_bad) begin
          app_error <= 1'b1;  // sticky until reset
        end else begin
          case (cmd_opcode)
            op_config: begin
              stride        <= cmd_param.cfg.stride;
              exp_clocks    <= cmd_param.cfg.exposure_clocks;
              exposure_bits <= cmd_exposure;
            end
            op_start: begin
              if (state != st_idle) begin
                app_error <= 1'b1;  // START during a burst is dropped
              end else if (cmd_param.run.frame_count == 16'd0) begin
                done_seen <= 1'b1;  // empty burst
              end else begin
                frame_total <= cmd_param.run.frame_count;
                frame_idx   <= '0;
                state       <= st_emit;
              end
            end
            default: ;  // nop
          endcase
        end
      end

      case (state)
        st_emit: begin
          if (frame_wren) begin
            frame_idx <= frame_idx + 16'd1;
            if (frame_idx + 16'd1 == frame_total) begin
              state     <= st_idle;
              done_seen <= 1'b1;
            end else if (exp_clocks > 16'd1) begin
              pace  <= exp_clocks - 16'd2;
              state <= st_wait;
            end
            // 0 or 1 clock period, next frame right away
          end
        end
        st_wait: begin
          if (pace == 16'd0) begin
            state <= st_emit;
          end else begin
            pace <= pace - 16'd1;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/upstream_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module upstream_serializer (
  input  wire logic                                   BUS_CLK,
  input  wire logic                                   rst_n,
  input  wire logic [host_link_pkg::frame_msg_w-1:0]  fifo_dout,
  input  wire logic                                   fifo_empty,
  output logic                                        fifo_rden,
  input  wire logic                                   burst_done,
  input  wire logic                                   rd_rden,
  output logic      [host_link_pkg::host_word_w-1:0]  rd_data,
  output logic                                        rd_empty,
  output logic                                        rd_eof
);

  import host_link_pkg::*;

  logic half;  // 1 once the low word has gone out
  logic take;

  assign rd_empty  = fifo_empty;
  assign take      = rd_rden && !fifo_empty;
  assign fifo_rden = take && half;  // pop after the high word

  assign rd_data = half ? fifo_dout[frame_msg_w-1:host_word_w]
                        : fifo_dout[host_word_w-1:0];

  // nothing left to drain and the sequencer has finished
  assign rd_eof = burst_done && fifo_empty && !half;

  always_ff @(posedge BUS_CLK or negedge rst_n) begin
    if (!rst_n) begin
      half <= 1'b0;
    end else if (take) begin
      half <= !half;
    end
  end

endmodule

`default_nettype wire

/* hdl/host_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module host_link_top #(
  parameter int cmd_depth   = 16,
  parameter int frame_depth = 8
) (
  input  wire logic                                   BUS_CLK,
  input  wire logic                                   rst_n,
  input  wire logic                                   wr_wren,
  input  wire logic [host_link_pkg::host_word_w-1:0]  wr_data,
  output logic                                        wr_full,
  input  wire logic                                   rd_rden,
  output logic      [host_link_pkg::host_word_w-1:0]  rd_data,
  output logic                                        rd_empty,
  output logic                                        rd_eof,
  output logic                                        app_running,
  output logic                                        app_error
);

  import host_link_pkg::*;

  logic [host_word_w-1:0] cmd_dout;
  logic                   cmd_empty;
  logic                   cmd_rden;
  logic                   cmd_valid;
  logic [opcode_w-1:0]    cmd_opcode;
  param_word_u            cmd_param;
  logic [host_word_w-1:0] cmd_exposure;
  logic                   cmd_bad;
  logic                   cmd_take;
  logic                   frame_wren;
  logic [frame_msg_w-1:0] frame_data;
  logic                   frame_high;
  logic [frame_msg_w-1:0] frame_dout;
  logic                   frame_empty;
  logic                   frame_rden;
  logic                   burst_done;

  // host write stream, high-water flag throttles the host
  stream_fifo #(.width(host_word_w), .depth(cmd_depth)) cmd_fifo (
    .BUS_CLK(BUS_CLK), .rst_n(rst_n),
    .din(wr_data), .wren(wr_wren), .rden(cmd_rden),
    .dout(cmd_dout), .empty(cmd_empty), .full(), .high(wr_full)
  );

  cmd_assembler cmd_assembler_i (
    .BUS_CLK(BUS_CLK), .rst_n(rst_n),
    .fifo_dout(cmd_dout), .fifo_empty(cmd_empty), .fifo_rden(cmd_rden),
    .cmd_valid(cmd_valid), .cmd_opcode(cmd_opcode), .cmd_param(cmd_param),
    .cmd_exposure(cmd_exposure), .cmd_bad(cmd_bad), .cmd_take(cmd_take)
  );

  frame_sequencer frame_sequencer_i (
    .BUS_CLK(BUS_CLK), .rst_n(rst_n),
    .cmd_valid(cmd_valid), .cmd_opcode(cmd_opcode), .cmd_param(cmd_param),
    .cmd_exposure(cmd_exposure), .cmd_bad(cmd_bad), .cmd_take(cmd_take),
    .frame_wren(frame_wren), .frame_data(frame_data), .frame_high(frame_high),
    .burst_done(burst_done), .app_running(app_running), .app_error(app_error)
  );

  stream_fifo #(.width(frame_msg_w), .depth(frame_depth)) frame_fifo (
    .BUS_CLK(BUS_CLK), .rst_n(rst_n),
    .din(frame_data), .wren(frame_wren), .rden(frame_rden),
    .dout(frame_dout), .empty(frame_empty), .full(), .high(frame_high)
  );

  upstream_serializer upstream_serializer_i (
    .BUS_CLK(BUS_CLK), .rst_n(rst_n),
    .fifo_dout(frame_dout), .fifo_empty(frame_empty), .fifo_rden(frame_rden),
    .burst_done(burst_done), .rd_rden(rd_rden), .rd_data(rd_data),
    .rd_empty(rd_empty), .rd_eof(rd_eof)
  );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 4
) (
  output logic BUS_CLK,
  output logic rst_n
);

  initial begin
    BUS_CLK = 1'b0;
    forever begin
      #(period_ns / 2) BUS_CLK = ~BUS_CLK;
    end
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge BUS_CLK);
    #1;
    rst_n = 1'b1;  // released just after an edge
  end

endmodule

`default_nettype wire

/* verification/host_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module host_link_tb;

  import host_link_pkg::*;

  localparam int settle_cycles = 16;
  localparam int flag_timeout  = 3000;
  localparam int read_timeout  = 1000;
  localparam int write_timeout = 2000;

  logic                   BUS_CLK;
  logic                   rst_n;
  logic                   wr_wren;
  logic [host_word_w-1:0] wr_data;
  logic                   wr_full;
  logic                   rd_rden;
  logic [host_word_w-1:0] rd_data;
  logic                   rd_empty;
  logic                   rd_eof;
  logic                   app_running;
  logic                   app_error;

  logic [31:0]            vec_mem [0:255];  // four words per record
  logic [host_word_w-1:0] rx_q [$];         // words taken from the read stream
  logic [frame_stride_w+frame_exposure_w-1:0] burst_cfg_q [$];  // config seen by each START
  logic [frame_stride_w-1:0]   model_stride = '0;
  logic [frame_exposure_w-1:0] model_exp    = '0;
  int                     hold_cycles  = 0;
  logic                   running_seen  = 1'b0;  // app_running high since last flag record
  logic                   burst_started = 1'b0;  // valid START sent since last flag record
  logic                   full_seen     = 1'b0;  // host had to wait on wr_full

  tb_clock_gen #(.period_ns(10), .reset_cycles(4)) clock_gen_i (
    .BUS_CLK(BUS_CLK), .rst_n(rst_n)
  );

  host_link_top #(.cmd_depth(16), .frame_depth(8)) host_link_top_i (
    .BUS_CLK(BUS_CLK), .rst_n(rst_n),
    .wr_wren(wr_wren), .wr_data(wr_data), .wr_full(wr_full),
    .rd_rden(rd_rden), .rd_data(rd_data), .rd_empty(rd_empty), .rd_eof(rd_eof),
    .app_running(app_running), .app_error(app_error)
  );

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [host_word_w-1:0] exp_v,
                            input logic [host_word_w-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp_v, act_v);
      stop_run();
    end
  endtask

  task automatic check_frame(input string name, input logic [frame_msg_w-1:0] exp_v,
                             input logic [frame_msg_w-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp_v, act_v);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp_v, act_v);
      stop_run();
    end
  endtask

  // random read strobe, or low while a hold is running
  initial begin : read_driver
    rd_rden = 1'b0;
    void'($urandom(58981));
    forever begin
      @(posedge BUS_CLK);
      #1;
      if (hold_cycles > 0) begin
        hold_cycles = hold_cycles - 1;
        rd_rden = 1'b0;
      end else begin
        rd_rden = ($urandom % 4) != 0;
      end
    end
  end

  // a word shown here is consumed at the next edge
  always @(negedge BUS_CLK) begin
    if (rst_n === 1'b1 && rd_rden && !rd_empty) begin
      rx_q.push_back(rd_data);
    end
    if (app_running === 1'b1) begin
      running_seen = 1'b1;  // cleared at each flag record
    end
  end

  // called 1 ns after an edge, returns 1 ns after an edge
  task automatic send_word(input logic [host_word_w-1:0] word);
    int waited;
    waited = 0;
    while (wr_full) begin
      full_seen = 1'b1;
      if (waited == write_timeout) begin
        $display("host write stalled: wr_full stayed high for %0d cycles", waited);
        stop_run();
      end
      @(posedge BUS_CLK);
      #1;
      waited++;
    end
    wr_wren = 1'b1;
    wr_data = word;
    @(posedge BUS_CLK);
    #1;
    wr_wren = 1'b0;
  endtask

  task automatic pop_word(input string name, output logic [host_word_w-1:0] word);
    int waited;
    waited = 0;
    while (rx_q.size() == 0) begin
      if (waited == read_timeout) begin
        $display("%s: no read data arrived within %0d cycles", name, waited);
        stop_run();
      end
      @(posedge BUS_CLK);
      #1;
      waited++;
    end
    word = rx_q.pop_front();
  endtask

  task automatic expect_burst(input int count, input logic [frame_msg_w-1:0] frame0,
                              input string name);
    logic [frame_msg_w-1:0] model0;
    logic [frame_msg_w-1:0] exp_frame;
    logic [host_word_w-1:0] lo;
    logic [host_word_w-1:0] hi;
    int                     i;
    if (burst_cfg_q.size() == 0) begin
      $display("%s: a burst is expected but no START was sent", name);
      stop_run();
    end
    model0 = {frame_idx_w'(0), burst_cfg_q.pop_front()};
    check_frame({name, " model"}, model0, frame0);  // file against own model
    for (i = 0; i < count; i++) begin
      exp_frame = {frame_idx_w'(i), frame0[frame_stride_w+frame_exposure_w-1:0]};
      pop_word(name, lo);  // low word first
      pop_word(name, hi);
      check_word($sformatf("%s frame %0d low", name, i), exp_frame[host_word_w-1:0], lo);
      check_word($sformatf("%s frame %0d high", name, i),
                 exp_frame[frame_msg_w-1:host_word_w], hi);
      check_frame($sformatf("%s frame %0d", name, i), exp_frame, {hi, lo});
    end
  endtask

  // flags are {rd_empty, rd_eof, app_running, app_error}
  task automatic expect_flags(input logic [3:0] exp_flags, input string name);
    int         waited;
    int         stable;
    logic [3:0] now;
    waited = 0;
    stable = 0;
    while (stable < settle_cycles) begin
      if (waited == flag_timeout) begin
        check_flag({name, " rd_empty"}, exp_flags[3], rd_empty);
        check_flag({name, " rd_eof"}, exp_flags[2], rd_eof);
        check_flag({name, " app_running"}, exp_flags[1], app_running);
        check_flag({name, " app_error"}, exp_flags[0], app_error);
        $display("%s: status flags kept changing and never settled", name);
        stop_run();
      end
      @(negedge BUS_CLK);
      now    = {rd_empty, rd_eof, app_running, app_error};
      stable = (now === exp_flags) ? stable + 1 : 0;
      waited++;
    end
    @(posedge BUS_CLK);
    #1;
    check_flag({name, " wr_full"}, 1'b0, wr_full);  // all commands consumed
    check_flag({name, " app_running during burst"}, burst_started, running_seen);
    running_seen  = 1'b0;
    burst_started = 1'b0;
    if (rx_q.size() != 0) begin
      $display("%s: %0d read words arrived that no burst expected", name, rx_q.size());
      stop_run();
    end
  endtask

  initial begin : main
    int          idx;
    int          waited;
    bit          done;
    string       name;
    logic [31:0] kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    wr_wren = 1'b0;
    wr_data = '0;
    $readmemh("verification/host_link_vectors.txt", vec_mem);
    waited = 0;
    while (rst_n !== 1'b1) begin
      if (waited == 20) begin
        $display("reset was never released");
        stop_run();
      end
      @(posedge BUS_CLK);
      #1;
      waited++;
    end
    check_flag("reset rd_empty", 1'b1, rd_empty);
    check_flag("reset rd_eof", 1'b0, rd_eof);
    check_flag("reset wr_full", 1'b0, wr_full);
    check_flag("reset app_running", 1'b0, app_running);
    check_flag("reset app_error", 1'b0, app_error);
    idx  = 0;
    done = 1'b0;
    while (!done) begin
      if (idx > 252) begin
        $display("vector file has no end record");
        stop_run();
      end
      kind = vec_mem[idx];
      a    = vec_mem[idx+1];
      b    = vec_mem[idx+2];
      c    = vec_mem[idx+3];
      name = $sformatf("record %0d", idx / 4);
      case (kind)
        32'h1: begin  // one command, three words
          if (a[tag_lsb +: tag_w] == hdr_tag) begin
            if (a[opcode_lsb +: opcode_w] == op_config) begin
              model_stride = b[31:16];
              model_exp    = c;
            end else if (a[opcode_lsb +: opcode_w] == op_start && b[15:0] != 16'd0) begin
              burst_cfg_q.push_back({model_stride, model_exp});
              burst_started = 1'b1;
            end
          end
          send_word(a);
          send_word(b);
          send_word(c);
        end
        32'h2: expect_burst(int'(a[31:16]), {b, c}, name);
        32'h3: expect_flags(a[3:0], name);
        32'h4: begin  // hold the read strobe low
          @(negedge BUS_CLK);
          hold_cycles = int'(a);
          @(posedge BUS_CLK);
          #1;
        end
        32'hf: done = 1'b1;
        default: begin
          $display("%s: unknown record kind %h", name, kind);
          stop_run();
        end
      endcase
      idx = idx + 4;
    end
    check_flag("host writes throttled by wr_full", 1'b1, full_seen);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/host_link_vectors.txt */
// kind a b c, 1 command header/param/exposure, 2 burst {count,0}/frame0 hi/frame0 lo
// 3 flags {rd_empty,rd_eof,app_running,app_error}, 4 read hold cycles, f end of vectors
00000001 00000000 00000000 00000000 // nop
00000001 00000000 00000000 00000000 // nop
00000001 00000000 00000000 00000000 // nop
00000003 00000008 00000000 00000000
00000001 00000108 00120003 3c23d70a // config stride 0x12, 3 clocks
00000001 00000908 00000004 00000000 // start 4
00000002 00040000 00000012 3c23d70a
00000003 0000000c 00000000 00000000
00000001 00000908 00000002 00000000 // start 2, index restarts
00000002 00020000 00000012 3c23d70a
00000003 0000000c 00000000 00000000
00000004 00000190 00000000 00000000 // reader holds 400 cycles
00000001 00000908 0000000c 00000000 // start 12
00000002 000c0000 00000012 3c23d70a
00000003 0000000c 00000000 00000000
00000001 00000107 00ff0001 00000000 // wrong tag
00000001 00000508 00000000 00000000 // unknown opcode
00000003 0000000d 00000000 00000000
00000001 00000108 00400005 41200000 // config stride 0x40, 5 clocks
00000001 00000908 00000003 00000000 // start 3
00000002 00030000 00000040 41200000
00000003 0000000d 00000000 00000000
00000004 0000012c 00000000 00000000 // reader holds 300 cycles
00000001 00000908 0000000a 00000000 // start 10
00000001 00000108 00070002 bf800000 // config held until burst ends
00000001 00000000 00000000 00000000 // nop
00000001 00000000 00000000 00000000 // nop
00000001 00000000 00000000 00000000 // nop
00000001 00000108 01000001 3f000000 // config stride 0x100, 1 clock
00000001 00000908 00000005 00000000 // start 5
00000002 000a0000 00000040 41200000
00000002 00050000 00000100 3f000000
00000003 0000000d 00000000 00000000
0000000f 00000000 00000000 00000000

/* tb.f */
hdl/host_link_pkg.sv
hdl/stream_fifo.sv
hdl/cmd_assembler.sv
hdl/frame_sequencer.sv
hdl/upstream_serializer.sv
hdl/host_link_top.sv
verification/tb_clock_gen.sv
verification/host_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the host-link testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module host_link_tb \
  -f tb.f -o host_link_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/host_link_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit "$status"
fi

exit 0
